/* verilog/i3c_bus_pkg.sv */
// Bus line and timing types; all widths are fixed here and thresholds are in clock cycles
`default_nettype none

package i3c_bus_pkg;

  localparam int unsigned TimerWidth = 20;
  localparam int unsigned SyncStages = 2;
  localparam int unsigned RstPatternToggles = 14;
  localparam int unsigned ToggleCntWidth = 4;

  typedef logic [TimerWidth-1:0] timer_t;

  // Synchronized view of one bus line
  typedef struct packed {
    logic value;
    logic pos_edge;
    logic neg_edge;
    logic stable_high;
    logic stable_low;
  } bus_line_t;

  typedef struct packed {
    bus_line_t scl;
    bus_line_t sda;
    logic      start_det;
    logic      rstart_det;
    logic      stop_det;
  } bus_state_t;

  typedef struct packed {
    timer_t t_bus_free;
    timer_t t_bus_idle;
    timer_t t_bus_available;
  } bus_timing_t;

endpackage

`default_nettype wire

/* verilog/i3c_rstact_pkg.sv */
// RSTACT codes and request; the request arrives as a bare strobe and is never acknowledged
`default_nettype none

package i3c_rstact_pkg;

  typedef enum logic [7:0] {
    RstactNone       = 8'h00,
    RstactPeripheral = 8'h01,
    RstactEscalated  = 8'h02
  } rstact_e;

  // Codes outside rstact_e are legal and do nothing
  typedef struct packed {
    logic       valid;
    logic [7:0] action;
  } rstact_req_t;

endpackage

`default_nettype wire

/* verilog/i3c_bus_monitor.sv */
// Raw SCL/SDA are asynchronous; strobes lag the pins by 3 cycles and are zero while disabled
`timescale 1ns/1ps
`default_nettype none

module i3c_bus_monitor (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    scl_i,
  input  logic                    sda_i,
  output i3c_bus_pkg::bus_state_t bus_o
);

  logic [i3c_bus_pkg::SyncStages-1:0] scl_sync_q;
  logic [i3c_bus_pkg::SyncStages-1:0] sda_sync_q;
  logic scl;
  logic sda;
  logic scl_prev_q;
  logic sda_prev_q;
  logic scl_rise;
  logic scl_fall;
  logic sda_rise;
  logic sda_fall;
  logic start_c;
  logic stop_c;
  logic busy_q;
  // pos_edge, neg_edge, stable_high, stable_low
  logic [3:0] scl_flags_q;
  logic [3:0] sda_flags_q;
  logic start_q;
  logic rstart_q;
  logic stop_q;

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
    end else begin
      scl_sync_q <= {scl_sync_q[i3c_bus_pkg::SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[i3c_bus_pkg::SyncStages-2:0], sda_i};
    end
  end

  assign scl = scl_sync_q[i3c_bus_pkg::SyncStages-1];
  assign sda = sda_sync_q[i3c_bus_pkg::SyncStages-1];

  assign scl_rise = scl & ~scl_prev_q;
  assign scl_fall = ~scl & scl_prev_q;
  assign sda_rise = sda & ~sda_prev_q;
  assign sda_fall = ~sda & sda_prev_q;

  // SCL must be high on both sides of the SDA change
  assign start_c = sda_fall & scl & scl_prev_q;
  assign stop_c  = sda_rise & scl & scl_prev_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_prev_q  <= 1'b1;
      sda_prev_q  <= 1'b1;
      busy_q      <= 1'b0;
      scl_flags_q <= '0;
      sda_flags_q <= '0;
      start_q     <= 1'b0;
      rstart_q    <= 1'b0;
      stop_q      <= 1'b0;
    end else begin
      scl_prev_q  <= scl;
      sda_prev_q  <= sda;
      scl_flags_q <= {enable_i & scl_rise, enable_i & scl_fall,
                      scl & scl_prev_q, ~scl & ~scl_prev_q};
      sda_flags_q <= {enable_i & sda_rise, enable_i & sda_fall,
                      sda & sda_prev_q, ~sda & ~sda_prev_q};
      start_q     <= enable_i & start_c & ~busy_q;
      rstart_q    <= enable_i & start_c & busy_q;
      stop_q      <= enable_i & stop_c;
      // SCL held low by a controller also means the bus is in use
      if (!enable_i || stop_c) begin
        busy_q <= 1'b0;
      end else if (start_c || scl_fall) begin
        busy_q <= 1'b1;
      end
    end
  end

  assign bus_o = '{
    scl:        {scl, scl_flags_q},
    sda:        {sda, sda_flags_q},
    start_det:  start_q,
    rstart_det: rstart_q,
    stop_det:   stop_q
  };

  start_stop_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((bus_o.start_det || bus_o.rstart_det) && bus_o.stop_det));

endmodule

`default_nettype wire

/* verilog/target_reset_detector.sv */
// Needs exactly the toggle count, then Sr, then STOP; extra toggles after the count are ignored
`timescale 1ns/1ps
`default_nettype none

module target_reset_detector (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  i3c_bus_pkg::bus_state_t bus_i,
  output logic                    rst_pattern_det_o
);

  typedef enum logic [1:0] {
    PhCount,
    PhWaitSr,
    PhWaitStop
  } phase_e;

  phase_e phase_q;
  logic [i3c_bus_pkg::ToggleCntWidth-1:0] toggle_cnt_q;
  logic toggle;
  logic det_q;

  assign toggle = bus_i.scl.stable_low & (bus_i.sda.pos_edge | bus_i.sda.neg_edge);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q      <= PhCount;
      toggle_cnt_q <= '0;
      det_q        <= 1'b0;
    end else begin
      det_q <= 1'b0;
      unique case (phase_q)
        PhCount: begin
          // Clock activity means an ordinary transfer
          if (bus_i.scl.pos_edge) begin
            toggle_cnt_q <= '0;
          end else if (toggle) begin
            if (toggle_cnt_q ==
                i3c_bus_pkg::ToggleCntWidth'(i3c_bus_pkg::RstPatternToggles - 1)) begin
              toggle_cnt_q <= '0;
              phase_q      <= PhWaitSr;
            end else begin
              toggle_cnt_q <= toggle_cnt_q + 1'b1;
            end
          end
        end
        PhWaitSr: begin
          if (bus_i.rstart_det) begin
            phase_q <= PhWaitStop;
          end else if (bus_i.start_det || bus_i.stop_det || bus_i.scl.neg_edge) begin
            phase_q <= PhCount;
          end
        end
        PhWaitStop: begin
          if (bus_i.stop_det) begin
            det_q   <= 1'b1;
            phase_q <= PhCount;
          end else if (bus_i.scl.neg_edge || bus_i.start_det || bus_i.rstart_det) begin
            phase_q <= PhCount;
          end
        end
        default: phase_q <= PhCount;
      endcase
    end
  end

  assign rst_pattern_det_o = det_q;

  det_single_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rst_pattern_det_o |=> !rst_pattern_det_o);

endmodule

`default_nettype wire

/* verilog/bus_timers.sv */
// Counts clock cycles since STOP and saturates; a START drops all outputs until the next STOP
`timescale 1ns/1ps
`default_nettype none

module bus_timers (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     enable_i,
  input  i3c_bus_pkg::bus_state_t  bus_i,
  input  i3c_bus_pkg::bus_timing_t timing_i,
  output logic                     bus_free_o,
  output logic                     bus_idle_o,
  output logic                     bus_available_o
);

  i3c_bus_pkg::timer_t cnt_q;
  logic busy_q;

  // Saturated out of reset so the bus counts as idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '1;
      busy_q <= 1'b0;
    end else if (enable_i && bus_i.stop_det) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
    end else begin
      if (cnt_q != '1) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (enable_i && bus_i.start_det) begin
        busy_q <= 1'b1;
      end
    end
  end

  assign bus_free_o      = ~busy_q & (cnt_q >= timing_i.t_bus_free);
  assign bus_available_o = ~busy_q & (cnt_q >= timing_i.t_bus_available);
  assign bus_idle_o      = ~busy_q & (cnt_q >= timing_i.t_bus_idle);

  idle_implies_avail_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (timing_i.t_bus_idle >= timing_i.t_bus_available) && bus_idle_o |-> bus_available_o);

endmodule

`default_nettype wire

/* verilog/reset_action_ctrl.sv */
// An armed RSTACT overrides only the next pattern; escalated reset clears only on rst_ni
`timescale 1ns/1ps
`default_nettype none

module reset_action_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  i3c_bus_pkg::bus_state_t    bus_i,
  input  logic                       rst_pattern_det_i,
  input  i3c_rstact_pkg::rstact_req_t rstact_i,
  input  logic                       peripheral_reset_done_i,
  output logic                       peripheral_reset_o,
  output logic                       escalated_reset_o
);

  logic [7:0] action_q;
  logic armed_q;
  logic escalate_q;
  logic periph_req;
  logic escal_req;

  always_ff @(posedge clk_i) begin
    if (rstact_i.valid) begin
      action_q <= rstact_i.action;
    end
  end

  always_comb begin
    periph_req = 1'b0;
    escal_req  = 1'b0;
    if (rst_pattern_det_i) begin
      if (armed_q) begin
        // Unknown codes and RstactNone give no reset
        periph_req = (action_q == i3c_rstact_pkg::RstactPeripheral);
        escal_req  = (action_q == i3c_rstact_pkg::RstactEscalated);
      end else if (escalate_q) begin
        escal_req = 1'b1;
      end else begin
        periph_req = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed_q            <= 1'b0;
      escalate_q         <= 1'b0;
      peripheral_reset_o <= 1'b0;
      escalated_reset_o  <= 1'b0;
    end else begin
      if (rst_pattern_det_i && armed_q) begin
        armed_q <= 1'b0;
      end
      if (rstact_i.valid) begin
        armed_q <= 1'b1;
      end
      // A fresh START ends the escalation window but Sr does not
      if (bus_i.start_det) begin
        escalate_q <= 1'b0;
      end
      if (rst_pattern_det_i && !armed_q) begin
        escalate_q <= 1'b1;
      end
      if (peripheral_reset_done_i) begin
        peripheral_reset_o <= 1'b0;
      end else if (periph_req) begin
        peripheral_reset_o <= 1'b1;
      end
      if (escal_req) begin
        escalated_reset_o <= 1'b1;
      end
    end
  end

  periph_done_wins_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    peripheral_reset_done_i |=> !$rose(peripheral_reset_o));

endmodule

`default_nettype wire

/* verilog/i3c_target_reset_top.sv */
// Pattern STOP at the pins reaches a reset output after 5 cycles; no handshake on any port
`timescale 1ns/1ps
`default_nettype none

module i3c_target_reset_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        enable_i,
  input  logic                        scl_i,
  input  logic                        sda_i,
  input  i3c_bus_pkg::bus_timing_t    timing_i,
  input  i3c_rstact_pkg::rstact_req_t rstact_i,
  input  logic                        peripheral_reset_done_i,
  output logic                        peripheral_reset_o,
  output logic                        escalated_reset_o,
  output logic                        bus_free_o,
  output logic                        bus_idle_o,
  output logic                        bus_available_o
);

  i3c_bus_pkg::bus_state_t bus;
  logic rst_pattern_det;

  i3c_bus_monitor u_bus_monitor (
    .clk_i,
    .rst_ni,
    .enable_i,
    .scl_i,
    .sda_i,
    .bus_o (bus)
  );

  target_reset_detector u_target_reset_detector (
    .clk_i,
    .rst_ni,
    .bus_i             (bus),
    .rst_pattern_det_o (rst_pattern_det)
  );

  bus_timers u_bus_timers (
    .clk_i,
    .rst_ni,
    .enable_i,
    .bus_i (bus),
    .timing_i,
    .bus_free_o,
    .bus_idle_o,
    .bus_available_o
  );

  reset_action_ctrl u_reset_action_ctrl (
    .clk_i,
    .rst_ni,
    .bus_i             (bus),
    .rst_pattern_det_i (rst_pattern_det),
    .rstact_i,
    .peripheral_reset_done_i,
    .peripheral_reset_o,
    .escalated_reset_o
  );

endmodule

`default_nettype wire

/* sim/tb_i3c_target_reset.sv */
// Run from the project root; bus thresholds are fixed at 20, 40 and 100 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_i3c_target_reset;

  localparam int unsigned ClkPeriod = 20;
  localparam int unsigned StepDelay = 2;
  localparam int unsigned ResetCycles = 4;
  localparam int unsigned MaxSteps = 256;
  localparam int unsigned MinHold = 4;
  localparam int unsigned HoldBits = 3;
  localparam int unsigned MaxHold = MinHold + (1 << HoldBits) - 1;
  localparam int unsigned WatchdogMargin = 200;
  localparam logic [15:0] LfsrSeed = 16'd31;
  localparam logic [15:0] LfsrTaps = 16'hB400;

  // Opcode in the top hex digit of each step word
  localparam logic [3:0] OpEnd = 4'h0;
  localparam logic [3:0] OpDrive = 4'h1;
  localparam logic [3:0] OpRstact = 4'h2;
  localparam logic [3:0] OpDone = 4'h3;
  localparam logic [3:0] OpExpect = 4'h4;
  localparam logic [3:0] OpReset = 4'h5;
  localparam logic [3:0] OpToggle = 4'h6;
  localparam logic [3:0] OpEnable = 4'h7;

  logic clk_i;
  logic rst_ni;
  logic enable_i;
  logic scl_i;
  logic sda_i;
  i3c_bus_pkg::bus_timing_t timing_i;
  i3c_rstact_pkg::rstact_req_t rstact_i;
  logic peripheral_reset_done_i;
  logic peripheral_reset_o;
  logic escalated_reset_o;
  logic bus_free_o;
  logic bus_idle_o;
  logic bus_available_o;

  logic [31:0] steps [MaxSteps];
  logic [15:0] lfsr_q;
  int unsigned error_count;
  int unsigned check_count;
  int unsigned budget_cycles;
  logic budget_ready;

  i3c_target_reset_top dut_i (
    .clk_i,
    .rst_ni,
    .enable_i,
    .scl_i,
    .sda_i,
    .timing_i,
    .rstact_i,
    .peripheral_reset_done_i,
    .peripheral_reset_o,
    .escalated_reset_o,
    .bus_free_o,
    .bus_idle_o,
    .bus_available_o
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic [15:0] state_n;
    state_n = state >> 1;
    if (state[0]) begin
      state_n = state_n ^ LfsrTaps;
    end
    return state_n;
  endfunction

  // One LFSR step for every bit taken
  task automatic draw_bits(input int unsigned width, output int unsigned value);
    value = 0;
    for (int unsigned i = 0; i < width; i++) begin
      value = (value << 1) | {31'd0, lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[FAIL] time %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Inputs change a short delay after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #StepDelay;
  endtask

  task automatic hold_cycles(input int unsigned count);
    repeat (count) next_cycle();
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    hold_cycles(ResetCycles);
    rst_ni = 1'b1;
  endtask

  // SCL stays where the previous drive step left it
  task automatic toggle_sda(input int unsigned toggles);
    int unsigned hold;
    for (int unsigned i = 0; i < toggles; i++) begin
      draw_bits(HoldBits, hold);
      sda_i = ~sda_i;
      hold_cycles(MinHold + hold);
    end
  endtask

  function automatic int unsigned step_cycles(input logic [31:0] step);
    case (step[31:28])
      OpDrive: return {12'd0, step[19:0]};
      OpToggle: return {24'd0, step[7:0]} * MaxHold;
      OpRstact, OpDone: return 1;
      OpReset: return ResetCycles;
      default: return 0;
    endcase
  endfunction

  task automatic run_step(input logic [31:0] step);
    case (step[31:28])
      OpDrive: begin
        scl_i = step[24];
        sda_i = step[20];
        hold_cycles({12'd0, step[19:0]});
      end
      OpRstact: begin
        rstact_i.valid = 1'b1;
        rstact_i.action = step[7:0];
        next_cycle();
        rstact_i = '0;
      end
      OpDone: begin
        peripheral_reset_done_i = 1'b1;
        next_cycle();
        peripheral_reset_done_i = 1'b0;
      end
      OpExpect: begin
        check_value("peripheral_reset_o", 32'(peripheral_reset_o), 32'(step[16]));
        check_value("escalated_reset_o", 32'(escalated_reset_o), 32'(step[12]));
        check_value("bus_free_o", 32'(bus_free_o), 32'(step[8]));
        check_value("bus_available_o", 32'(bus_available_o), 32'(step[4]));
        check_value("bus_idle_o", 32'(bus_idle_o), 32'(step[0]));
      end
      OpReset: apply_reset();
      OpToggle: toggle_sda({24'd0, step[7:0]});
      OpEnable: enable_i = step[0];
      default: begin
        error_count++;
        $display("Unknown opcode %0h in the pattern file", step[31:28]);
      end
    endcase
  endtask

  initial begin : watchdog
    wait (budget_ready);
    repeat (budget_cycles) @(posedge clk_i);
    $display("Timeout: the steps did not finish within %0d cycles", budget_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : run_sequence
    int unsigned n_steps;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    enable_i = 1'b1;
    scl_i = 1'b1;
    sda_i = 1'b1;
    timing_i.t_bus_free = 20'd20;
    timing_i.t_bus_available = 20'd40;
    timing_i.t_bus_idle = 20'd100;
    rstact_i = '0;
    peripheral_reset_done_i = 1'b0;
    lfsr_q = LfsrSeed;
    error_count = 0;
    check_count = 0;
    budget_ready = 1'b0;
    budget_cycles = WatchdogMargin + ResetCycles;
    foreach (steps[i]) begin
      steps[i] = '0;
    end
    $readmemh("sim/target_reset_patterns.txt", steps);
    n_steps = 0;
    while (n_steps < MaxSteps && steps[n_steps][31:28] != OpEnd) begin
      budget_cycles += step_cycles(steps[n_steps]);
      n_steps++;
    end
    budget_ready = 1'b1;
    if (n_steps == 0) begin
      error_count++;
      $display("The pattern file holds no steps");
    end
    apply_reset();
    for (int unsigned i = 0; i < n_steps; i++) begin
      run_step(steps[i]);
    end
    $display("Done: %0d steps, %0d checks, %0d errors", n_steps, check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
verilog/i3c_bus_pkg.sv
verilog/i3c_rstact_pkg.sv
verilog/i3c_bus_monitor.sv
verilog/target_reset_detector.sv
verilog/bus_timers.sv
verilog/reset_action_ctrl.sv
verilog/i3c_target_reset_top.sv
sim/tb_i3c_target_reset.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_i3c_target_reset
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q '^STATUS: PASS$$' $(LOG)

check:
	@test -f $(LOG) || { echo "no log found, run the simulation first"; exit 1; }
	@grep -q '^STATUS: PASS$$' $(LOG) && echo "simulation passed" || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/target_reset_patterns.txt */
// Word o_s_d_aaaaa: 1 drive scl=s sda=d for a cycles, 2 rstact code a, 3 done pulse, 4 expect,
// 5 reset, 6 toggle sda a times, 7 enable=a; expect digits: periph escal free avail idle
4_0_0_00111
// Normal transfer, thresholds 20/40/100
1_1_1_00004 1_1_0_00006 4_0_0_00000
1_0_0_00006 1_1_0_00006 4_0_0_00000
1_1_1_0000a 4_0_0_00000
1_1_1_0000b 4_0_0_00000
1_1_1_00006 4_0_0_00100
1_1_1_0000e 4_0_0_00100
1_1_1_00006 4_0_0_00110
1_1_1_00036 4_0_0_00110
1_1_1_00006 4_0_0_00111
// First pattern, then escalation without START
1_0_1_00004 6_0_0_0000e 1_1_1_00004 1_1_0_00004 1_1_1_00008 4_0_0_10000
1_1_1_00008 4_0_0_10000 3_0_0_00000 4_0_0_00000
1_0_1_00004 6_0_0_0000e 1_1_1_00004 1_1_0_00004 1_1_1_00008 4_0_0_01000
3_0_0_00000 1_1_1_00008 4_0_0_01000 5_0_0_00000 4_0_0_00111
// START between two patterns
1_0_1_00004 6_0_0_0000e 1_1_1_00004 1_1_0_00004 1_1_1_00008 4_0_0_10000
3_0_0_00000 1_1_0_00006 1_0_0_00006 1_1_0_00006 1_1_1_00008 4_0_0_00000
1_0_1_00004 6_0_0_0000e 1_1_1_00004 1_1_0_00004 1_1_1_00008 4_0_0_10000
3_0_0_00000 5_0_0_00000 4_0_0_00111
// Armed RSTACT 0x02 and 0x00, each followed by a default pattern
2_0_0_00002 1_0_1_00004 6_0_0_0000e 1_1_1_00004 1_1_0_00004 1_1_1_00008 4_0_0_01000
1_0_1_00004 6_0_0_0000e 1_1_1_00004 1_1_0_00004 1_1_1_00008 4_0_0_11000
3_0_0_00000 5_0_0_00000 4_0_0_00111
2_0_0_00000 1_0_1_00004 6_0_0_0000e 1_1_1_00004 1_1_0_00004 1_1_1_00008 4_0_0_00000
1_0_1_00004 6_0_0_0000e 1_1_1_00004 1_1_0_00004 1_1_1_00008 4_0_0_10000
3_0_0_00000 4_0_0_00000
// 13 toggles, then 14 toggles with STOP but no Sr
1_0_1_00004 6_0_0_0000d 1_1_0_00004 1_1_1_00008 4_0_0_00000
1_0_1_00004 6_0_0_0000e 1_0_0_00004 1_1_0_00004 1_1_1_00008 4_0_0_00000
// Disabled: pattern and transfer are ignored
1_1_1_0006e 4_0_0_00111
7_0_0_00000 1_0_1_00004 6_0_0_0000e 1_1_1_00004 1_1_0_00004 1_1_1_00008 4_0_0_00111
1_1_0_00006 1_0_0_00006 1_1_0_00006 1_1_1_00008 4_0_0_00111
7_0_0_00001 1_1_1_00008 4_0_0_00111
0_0_0_00000
